/* design/xpose_pkg.sv */
package xpose_pkg;

    // width of one real or imaginary part
    localparam int unsigned SAMPLE_W = 16;

    // bank address width, 32 entries per bank
    localparam int unsigned ADDR_W = 5;

    // grid is N_LANE rows by N_LANE columns
    localparam int unsigned N_LANE = 4;

    // row or column select width
    localparam int unsigned IDX_W = $clog2(N_LANE);

    // one real or imaginary value
    typedef logic [SAMPLE_W-1:0] sample_t;

    // four samples, lane 0 in the low bits
    typedef logic [N_LANE*SAMPLE_W-1:0] lane_vec_t;

    // bank address
    typedef logic [ADDR_W-1:0] addr_t;

    // row or column index
    typedef logic [IDX_W-1:0] idx_t;

    // command opcodes
    // code 2'd3 is not assigned and decodes as no operation
    typedef enum logic [1:0] {
        CMD_WR_ROW = 2'd0,
        CMD_RD_ROW = 2'd1,
        CMD_RD_COL = 2'd2
    } cmd_op_e;

endpackage

/* design/xpose_cmd_decode.sv */
`timescale 1ns/10ps

module xpose_cmd_decode import xpose_pkg::*; (
    input  logic                clk_i,
    input  logic                rst_n_i,
    // command side
    input  logic                cmd_valid_i,
    input  cmd_op_e             cmd_op_i,
    input  idx_t                cmd_idx_i,
    input  addr_t               cmd_addr_i,
    input  lane_vec_t           cmd_re_i,
    input  lane_vec_t           cmd_im_i,
    output logic                cmd_ready_o,
    // credit handshake with the return side
    input  logic                credit_ok_i,
    output logic                rd_issue_o,
    // registered strobes to the bank grid
    output logic [N_LANE-1:0]   wr_row_en_o,
    output logic                rd_en_o,
    output logic                rd_col_o,
    output idx_t                rd_idx_o,
    output addr_t               addr_o,
    output lane_vec_t           wr_re_o,
    output lane_vec_t           wr_im_o
);

    logic accept;
    logic is_wr;
    logic is_rd;

    // no credit means no command at all
    // writes wait too so they stay ordered behind the stalled reads
    assign cmd_ready_o = credit_ok_i;
    assign accept      = cmd_valid_i & cmd_ready_o;

    // opcode class
    always_comb begin
        is_wr = 1'b0;
        is_rd = 1'b0;
        case (cmd_op_i)
            CMD_WR_ROW: begin
                is_wr = 1'b1;
            end
            CMD_RD_ROW,
            CMD_RD_COL: begin
                is_rd = 1'b1;
            end
            default: begin
                // unused code, nothing happens
            end
        endcase
    end

    // spend the credit in the acceptance cycle
    assign rd_issue_o = accept & is_rd;

    // strobes, one cycle after acceptance
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            wr_row_en_o <= '0;
            rd_en_o     <= 1'b0;
        end else begin
            // one-hot row select for a row write
            wr_row_en_o <= '0;
            if (accept && is_wr) begin
                wr_row_en_o[cmd_idx_i] <= 1'b1;
            end
            rd_en_o <= accept & is_rd;
        end
    end

    // address, mode and index follow any accepted command
    always_ff @(posedge clk_i) begin
        if (accept) begin
            addr_o   <= cmd_addr_i;
            rd_idx_o <= cmd_idx_i;
            rd_col_o <= (cmd_op_i == CMD_RD_COL);
        end
    end

    // write lanes only change on a write
    always_ff @(posedge clk_i) begin
        if (accept && is_wr) begin
            wr_re_o <= cmd_re_i;
            wr_im_o <= cmd_im_i;
        end
    end

endmodule

/* design/xpose_bank.sv */
`timescale 1ns/10ps

module xpose_bank import xpose_pkg::*; (
    input  logic    clk_i,
    input  logic    we_i,
    input  addr_t   addr_i,
    input  sample_t wre_i,
    input  sample_t wim_i,
    output sample_t rre_o,
    output sample_t rim_o
);

    // real and imaginary storage, same depth
    sample_t mem_re [2**ADDR_W];
    sample_t mem_im [2**ADDR_W];

    // single port
    // a write cycle leaves the read register untouched
    always_ff @(posedge clk_i) begin
        if (we_i) begin
            mem_re[addr_i] <= wre_i;
            mem_im[addr_i] <= wim_i;
        end else begin
            // registered read on every idle edge
            rre_o <= mem_re[addr_i];
            rim_o <= mem_im[addr_i];
        end
    end

endmodule

/* design/xpose_bank_array.sv */
`timescale 1ns/10ps

module xpose_bank_array import xpose_pkg::*; (
    input  logic                clk_i,
    input  logic                rst_n_i,
    // strobes from the decoder
    input  logic [N_LANE-1:0]   wr_row_en_i,
    input  logic                rd_en_i,
    input  logic                rd_col_i,
    input  idx_t                rd_idx_i,
    input  addr_t               addr_i,
    input  lane_vec_t           wr_re_i,
    input  lane_vec_t           wr_im_i,
    // steered read lanes
    output logic                rd_valid_o,
    output lane_vec_t           rd_re_o,
    output lane_vec_t           rd_im_o
);

    // bank outputs, indexed [row][column]
    sample_t bank_re [N_LANE][N_LANE];
    sample_t bank_im [N_LANE][N_LANE];

    // read mode and index, aligned with the bank read register
    logic rd_col_q;
    idx_t rd_idx_q;

    // 4x4 grid
    // all banks share one address
    // a row write enables the four banks of that row
    for (genvar r = 0; r < N_LANE; r++) begin : g_row
        for (genvar c = 0; c < N_LANE; c++) begin : g_col
            // lane c lands in column c
            xpose_bank xpose_bank_i (
                .clk_i (clk_i),
                .we_i  (wr_row_en_i[r]),
                .addr_i(addr_i),
                .wre_i (wr_re_i[c*SAMPLE_W +: SAMPLE_W]),
                .wim_i (wr_im_i[c*SAMPLE_W +: SAMPLE_W]),
                .rre_o (bank_re[r][c]),
                .rim_o (bank_im[r][c])
            );
        end
    end

    // valid lines up with the bank read data
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rd_valid_o <= 1'b0;
        end else begin
            rd_valid_o <= rd_en_i;
        end
    end

    // hold mode and index for the steering stage
    always_ff @(posedge clk_i) begin
        if (rd_en_i) begin
            rd_col_q <= rd_col_i;
            rd_idx_q <= rd_idx_i;
        end
    end

    // lane steering
    // row read: lane k from (sel row, column k)
    // column read: lane k from (row k, sel column), which transposes
    always_comb begin
        for (int k = 0; k < N_LANE; k++) begin
            if (rd_col_q) begin
                rd_re_o[k*SAMPLE_W +: SAMPLE_W] = bank_re[k][rd_idx_q];
                rd_im_o[k*SAMPLE_W +: SAMPLE_W] = bank_im[k][rd_idx_q];
            end else begin
                rd_re_o[k*SAMPLE_W +: SAMPLE_W] = bank_re[rd_idx_q][k];
                rd_im_o[k*SAMPLE_W +: SAMPLE_W] = bank_im[rd_idx_q][k];
            end
        end
    end

endmodule

/* design/xpose_rd_return.sv */
`timescale 1ns/10ps

module xpose_rd_return import xpose_pkg::*; #(
    // consumer buffer size, 1 to 8
    parameter int unsigned RSP_CREDITS = 2
) (
    input  logic        clk_i,
    input  logic        rst_n_i,
    // read accepted this cycle
    input  logic        rd_issue_i,
    // read data from the bank grid
    input  logic        rd_valid_i,
    input  lane_vec_t   rd_re_i,
    input  lane_vec_t   rd_im_i,
    // credit back from the consumer
    input  logic        rsp_credit_i,
    output logic        credit_ok_o,
    // response side
    output logic        rsp_valid_o,
    output lane_vec_t   rsp_re_o,
    output lane_vec_t   rsp_im_o
);

    // counter must hold the full credit count
    localparam int unsigned CNT_W = $clog2(RSP_CREDITS + 1);

    logic [CNT_W-1:0] credit_cnt;

    // credits left in the consumer buffer
    // issue and return in one edge cancel out
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            credit_cnt <= CNT_W'(RSP_CREDITS);
        end else begin
            case ({rd_issue_i, rsp_credit_i})
                2'b10: begin
                    credit_cnt <= credit_cnt - 1'b1;
                end
                2'b01: begin
                    credit_cnt <= credit_cnt + 1'b1;
                end
                default: begin
                    credit_cnt <= credit_cnt;
                end
            endcase
        end
    end

    // decoder only issues while this is high, so no underflow
    assign credit_ok_o = (credit_cnt != '0);

    // response valid, one pulse per read
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rsp_valid_o <= 1'b0;
        end else begin
            rsp_valid_o <= rd_valid_i;
        end
    end

    // response lanes, captured only with valid data
    always_ff @(posedge clk_i) begin
        if (rd_valid_i) begin
            rsp_re_o <= rd_re_i;
            rsp_im_o <= rd_im_i;
        end
    end

endmodule

/* design/xpose_mem_top.sv */
`timescale 1ns/10ps

module xpose_mem_top import xpose_pkg::*; #(
    // consumer buffer size
    parameter int unsigned RSP_CREDITS = 2
) (
    input  logic        clk_i,
    input  logic        rst_n_i,
    // command side
    input  logic        cmd_valid_i,
    output logic        cmd_ready_o,
    input  cmd_op_e     cmd_op_i,
    input  idx_t        cmd_idx_i,
    input  addr_t       cmd_addr_i,
    input  lane_vec_t   cmd_re_i,
    input  lane_vec_t   cmd_im_i,
    // response side, credit flow control
    output logic        rsp_valid_o,
    output lane_vec_t   rsp_re_o,
    output lane_vec_t   rsp_im_o,
    input  logic        rsp_credit_i
);

    // decoder to return side
    logic               credit_ok;
    logic               rd_issue;

    // decoder to bank grid
    logic [N_LANE-1:0]  wr_row_en;
    logic               rd_en;
    logic               rd_col;
    idx_t               rd_idx;
    addr_t              addr;
    lane_vec_t          wr_re;
    lane_vec_t          wr_im;

    // bank grid to return side
    logic               rd_valid;
    lane_vec_t          rd_re;
    lane_vec_t          rd_im;

    // command accept and strobe register
    xpose_cmd_decode xpose_cmd_decode_i (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .cmd_valid_i(cmd_valid_i),
        .cmd_op_i   (cmd_op_i),
        .cmd_idx_i  (cmd_idx_i),
        .cmd_addr_i (cmd_addr_i),
        .cmd_re_i   (cmd_re_i),
        .cmd_im_i   (cmd_im_i),
        .cmd_ready_o(cmd_ready_o),
        .credit_ok_i(credit_ok),
        .rd_issue_o (rd_issue),
        .wr_row_en_o(wr_row_en),
        .rd_en_o    (rd_en),
        .rd_col_o   (rd_col),
        .rd_idx_o   (rd_idx),
        .addr_o     (addr),
        .wr_re_o    (wr_re),
        .wr_im_o    (wr_im)
    );

    // 4x4 grid with row and column steering
    xpose_bank_array xpose_bank_array_i (
        .clk_i      (clk_i),
        .rst_n_i    (rst_n_i),
        .wr_row_en_i(wr_row_en),
        .rd_en_i    (rd_en),
        .rd_col_i   (rd_col),
        .rd_idx_i   (rd_idx),
        .addr_i     (addr),
        .wr_re_i    (wr_re),
        .wr_im_i    (wr_im),
        .rd_valid_o (rd_valid),
        .rd_re_o    (rd_re),
        .rd_im_o    (rd_im)
    );

    // response register and credit count
    xpose_rd_return #(
        .RSP_CREDITS(RSP_CREDITS)
    ) xpose_rd_return_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .rd_issue_i  (rd_issue),
        .rd_valid_i  (rd_valid),
        .rd_re_i     (rd_re),
        .rd_im_i     (rd_im),
        .rsp_credit_i(rsp_credit_i),
        .credit_ok_o (credit_ok),
        .rsp_valid_o (rsp_valid_o),
        .rsp_re_o    (rsp_re_o),
        .rsp_im_o    (rsp_im_o)
    );

endmodule

/* dv/tb_xpose_mem.sv */
`timescale 1ns/10ps

module tb_xpose_mem import xpose_pkg::*; ();

    localparam int RSP_CREDITS = 2;
    localparam int MAX_REC     = 48;
    // words per trace record
    localparam int REC_W       = 5;

    logic       clk_i;
    logic       rst_n_i;
    logic       cmd_valid_i;
    logic       cmd_ready_o;
    cmd_op_e    cmd_op_i;
    idx_t       cmd_idx_i;
    addr_t      cmd_addr_i;
    lane_vec_t  cmd_re_i;
    lane_vec_t  cmd_im_i;
    logic       rsp_valid_o;
    lane_vec_t  rsp_re_o;
    lane_vec_t  rsp_im_o;
    logic       rsp_credit_i;

    logic [63:0] trace_mem [MAX_REC*REC_W];
    int          n_rec;

    // expected responses in command order
    lane_vec_t exp_re_q[$];
    lane_vec_t exp_im_q[$];
    // cycle at which each consumer credit goes back
    int        due_q[$];

    integer seed;
    int     cycles;
    int     cycle_limit;
    int     rsp_total;
    int     credit_total;
    // credit hold bookkeeping
    logic   hold_on;
    int     hold_reads;
    int     hold_rsp;
    int     withheld;

    xpose_mem_top #(
        .RSP_CREDITS(RSP_CREDITS)
    ) xpose_mem_top_i (
        .clk_i       (clk_i),
        .rst_n_i     (rst_n_i),
        .cmd_valid_i (cmd_valid_i),
        .cmd_ready_o (cmd_ready_o),
        .cmd_op_i    (cmd_op_i),
        .cmd_idx_i   (cmd_idx_i),
        .cmd_addr_i  (cmd_addr_i),
        .cmd_re_i    (cmd_re_i),
        .cmd_im_i    (cmd_im_i),
        .rsp_valid_o (rsp_valid_o),
        .rsp_re_o    (rsp_re_o),
        .rsp_im_o    (rsp_im_o),
        .rsp_credit_i(rsp_credit_i)
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    task automatic report_failure(input string why);
        $display("%s", why);
        $display("Simulation failed");
        $fatal(1);
    endtask

    task automatic compare_value(input string name, input logic [63:0] got,
                                 input logic [63:0] exp);
        if (got !== exp) begin
            report_failure($sformatf("Mismatch %s got %h expected %h", name, got, exp));
        end
    endtask

    // nothing in flight and every credit back with the consumer
    task automatic wait_drained();
        while (exp_re_q.size() != 0 || due_q.size() != 0 || withheld != 0) begin
            @(negedge clk_i);
        end
    endtask

    // run length guard
    always @(posedge clk_i) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            report_failure("Timeout: the run did not finish within the cycle limit");
        end
    end

    // consumer checks each response and hands back its buffer entry later
    always @(negedge clk_i) begin
        lane_vec_t exp_re;
        lane_vec_t exp_im;
        int        delay;
        if (rsp_valid_o === 1'b1) begin
            if (exp_re_q.size() == 0) begin
                report_failure("A response arrived while no read was outstanding");
            end
            exp_re = exp_re_q.pop_front();
            exp_im = exp_im_q.pop_front();
            compare_value("rsp_re_o", rsp_re_o, exp_re);
            compare_value("rsp_im_o", rsp_im_o, exp_im);
            rsp_total = rsp_total + 1;
            // buffer overflow means a send without credit
            if (rsp_total > credit_total + RSP_CREDITS) begin
                report_failure("The DUT sent a response without a free credit");
            end
            if (hold_on) begin
                withheld = withheld + 1;
                hold_rsp = hold_rsp + 1;
            end else begin
                delay = $unsigned($random(seed)) % 6;
                due_q.push_back(cycles + 1 + delay);
            end
        end
        // hold released so give back what was kept
        if (!hold_on) begin
            while (withheld > 0) begin
                due_q.push_back(cycles);
                withheld = withheld - 1;
            end
        end
        // at most one credit pulse per cycle
        if (due_q.size() > 0 && due_q[0] <= cycles) begin
            void'(due_q.pop_front());
            rsp_credit_i = 1'b1;
            credit_total = credit_total + 1;
        end else begin
            rsp_credit_i = 1'b0;
        end
    end

    initial begin
        logic [63:0] ctl;
        logic        is_rd;
        logic        hold_rec;
        logic        accepted;
        seed         = 32'hfa2d_9ce4;
        cycles       = 0;
        cycle_limit  = 0;
        rsp_total    = 0;
        credit_total = 0;
        hold_on      = 1'b0;
        hold_reads   = 0;
        hold_rsp     = 0;
        withheld     = 0;
        rst_n_i      = 1'b0;
        cmd_valid_i  = 1'b0;
        cmd_op_i     = CMD_WR_ROW;
        cmd_idx_i    = '0;
        cmd_addr_i   = '0;
        cmd_re_i     = '0;
        cmd_im_i     = '0;
        rsp_credit_i = 1'b0;

        $readmemh("dv/xpose_trace.txt", trace_mem);
        // count records up to the end marker
        n_rec = -1;
        for (int i = 0; i < MAX_REC; i++) begin
            if (n_rec < 0 && trace_mem[i*REC_W][19:16] === 4'hf) begin
                n_rec = i;
            end
        end
        if (n_rec < 0) begin
            report_failure("The trace file has no end marker record");
        end
        cycle_limit = n_rec * 20 + 200;

        repeat (10) @(posedge clk_i);
        @(negedge clk_i);
        rst_n_i = 1'b1;
        @(negedge clk_i);
        // idle state out of reset
        compare_value("rsp_valid_o", rsp_valid_o, 1'b0);
        compare_value("cmd_ready_o", cmd_ready_o, 1'b1);

        for (int i = 0; i < n_rec; i++) begin
            ctl      = trace_mem[i*REC_W];
            is_rd    = (ctl[13:12] == 2'd1) || (ctl[13:12] == 2'd2);
            hold_rec = (ctl[19:16] == 4'h1);
            // enter the hold phase with an empty pipe
            if (hold_rec && !hold_on) begin
                cmd_valid_i = 1'b0;
                wait_drained();
                hold_on    = 1'b1;
                hold_reads = 0;
                hold_rsp   = 0;
            end
            cmd_valid_i = 1'b1;
            cmd_op_i    = cmd_op_e'(ctl[13:12]);
            cmd_idx_i   = idx_t'(ctl[9:8]);
            cmd_addr_i  = addr_t'(ctl[4:0]);
            cmd_re_i    = trace_mem[i*REC_W+1];
            cmd_im_i    = trace_mem[i*REC_W+2];
            // all credits spent so the DUT must stall and stay quiet
            if (hold_on && hold_reads == RSP_CREDITS) begin
                repeat (12) begin
                    compare_value("cmd_ready_o", cmd_ready_o, 1'b0);
                    @(negedge clk_i);
                end
                compare_value("responses during credit hold", hold_rsp, RSP_CREDITS);
                hold_on = 1'b0;
            end
            // ready comes from the credit register and holds until the next rising edge
            accepted = 1'b0;
            while (!accepted) begin
                if (cmd_ready_o === 1'b1) begin
                    accepted = 1'b1;
                    if (is_rd) begin
                        exp_re_q.push_back(trace_mem[i*REC_W+3]);
                        exp_im_q.push_back(trace_mem[i*REC_W+4]);
                        if (hold_on) begin
                            hold_reads = hold_reads + 1;
                        end
                    end
                end
                @(negedge clk_i);
            end
        end
        cmd_valid_i = 1'b0;

        // let the last responses out and watch for strays
        while (exp_re_q.size() != 0) begin
            @(negedge clk_i);
        end
        repeat (10) @(negedge clk_i);
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

/* sources.f */
design/xpose_pkg.sv
design/xpose_cmd_decode.sv
design/xpose_bank.sv
design/xpose_bank_array.sv
design/xpose_rd_return.sv
design/xpose_mem_top.sv
dv/tb_xpose_mem.sv

/* dv/xpose_trace.txt */
// columns: ctl re im exp_re exp_im, lane 3 leftmost in each 64-bit lane word
// ctl digits: mode op idx addr(2), mode 1 holds credits, mode f ends the trace
// four rows at address 05
00005 a003a002a001a000 b003b002b001b000 0 0
00105 a013a012a011a010 b013b012b011b010 0 0
00205 a023a022a021a020 b023b022b021b020 0 0
00305 a033a032a031a030 b033b032b031b030 0 0
// row reads at 05
01005 0 0 a003a002a001a000 b003b002b001b000
01105 0 0 a013a012a011a010 b013b012b011b010
01205 0 0 a023a022a021a020 b023b022b021b020
01305 0 0 a033a032a031a030 b033b032b031b030
// column reads at 05, transposed
02005 0 0 a030a020a010a000 b030b020b010b000
02105 0 0 a031a021a011a001 b031b021b011b001
02205 0 0 a032a022a012a002 b032b022b012b002
02305 0 0 a033a023a013a003 b033b023b013b003
// second address 1a
0001a c103c102c101c100 d103d102d101d100 0 0
0011a c113c112c111c110 d113d112d111d110 0 0
0021a c123c122c121c120 d123d122d121d120 0 0
0031a c133c132c131c130 d133d132d131d130 0 0
0111a 0 0 c113c112c111c110 d113d112d111d110
0221a 0 0 c132c122c112c102 d132d122d112d102
01105 0 0 a013a012a011a010 b013b012b011b010
// overwrite row 2 at 05
00205 e023e022e021e020 f023f022f021f020 0 0
01205 0 0 e023e022e021e020 f023f022f021f020
01105 0 0 a013a012a011a010 b013b012b011b010
02005 0 0 a030e020a010a000 b030f020b010b000
02305 0 0 a033e023a013a003 b033f023b013b003
// unused opcode
03005 0 0 0 0
// credit hold, third read must stall
12105 0 0 a031e021a011a001 b031f021b011b001
11305 0 0 a033a032a031a030 b033b032b031b030
12205 0 0 a032e022a012a002 b032f022b012b002
// back to normal returns
0101a 0 0 c103c102c101c100 d103d102d101d100
0231a 0 0 c133c123c113c103 d133d123d113d103
f0000 0 0 0 0
